//--- hw/link_bridge_pkg.sv
//////////////////////////////////////////////////////////////////////
// widths, address field positions and enums shared by the memory to
// mesh link bridge RTL and its testbench
//////////////////////////////////////////////////////////////////////

package link_bridge_pkg;

  // memory side
  localparam int BP_ADDR_W = 32;
  localparam int BLOCK_W = 128;
  localparam int TAG_W = 8;

  // network side
  localparam int LINK_DATA_W = 32;
  localparam int LINK_ADDR_W = 12;
  localparam int X_W = 4;
  localparam int Y_W = 4;

  localparam int NUM_FLITS = BLOCK_W / LINK_DATA_W;
  localparam int FLIT_IDX_W = $clog2(NUM_FLITS);
  localparam int BYTE_OFF_W = $clog2(LINK_DATA_W / 8);

  // block address bits above byte offset and flit index
  localparam int BLK_LSB = BYTE_OFF_W + FLIT_IDX_W;
  localparam int BLK_ADDR_W = LINK_ADDR_W - FLIT_IDX_W - 1;
  // destination column sits just above the word address
  localparam int X_LSB = BYTE_OFF_W + LINK_ADDR_W - 1;

  typedef enum logic {
    CMD_WRITEBACK = 1'b0,
    CMD_READ      = 1'b1
  } cmd_op_e;

  typedef enum logic {
    PKT_STORE = 1'b0,
    PKT_LOAD  = 1'b1
  } pkt_op_e;

  typedef enum logic [1:0] {
    ST_IDLE     = 2'd0,
    ST_SEND     = 2'd1,
    ST_WAIT_RET = 2'd2,
    ST_RESP     = 2'd3
  } ctrl_state_e;

endpackage

//--- hw/link_bridge_ctrl.sv
//////////////////////////////////////////////////////////////////////
// bridge controller: accepts one command, walks the flits out, waits
// for read returns and issues the memory response
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module link_bridge_ctrl (
  input  logic                                   clk_i
  , input  logic                                 reset_i
  , input  logic                                 cmd_valid_i
  , input  link_bridge_pkg::cmd_op_e             cmd_op_i
  , input  logic                                 pkt_ready_i
  , input  logic                                 all_returned_i
  , input  logic                                 resp_ready_i
  , output logic                                 cmd_ready_o
  , output logic                                 load_en_o
  , output logic                                 pkt_valid_o
  , output logic [link_bridge_pkg::FLIT_IDX_W-1:0] flit_idx_o
  , output logic                                 tracker_clear_o
  , output logic                                 ret_ready_o
  , output logic                                 resp_valid_o
);

  import link_bridge_pkg::*;

  ctrl_state_e state_r, state_n;
  cmd_op_e op_r;
  logic [FLIT_IDX_W-1:0] flit_idx_r;
  logic pkt_fire;
  logic last_flit;

  // handshake outputs come straight from the state
  assign cmd_ready_o = (state_r == ST_IDLE);
  assign pkt_valid_o = (state_r == ST_SEND);
  assign ret_ready_o = (state_r == ST_WAIT_RET);
  assign resp_valid_o = (state_r == ST_RESP);

  assign load_en_o = cmd_valid_i & cmd_ready_o;
  assign tracker_clear_o = load_en_o;
  assign flit_idx_o = flit_idx_r;

  assign pkt_fire = pkt_valid_o & pkt_ready_i;
  assign last_flit = (flit_idx_r == FLIT_IDX_W'(NUM_FLITS - 1));

  always_comb begin
    state_n = state_r;
    case (state_r)
      ST_IDLE: begin
        if (load_en_o) begin
          state_n = ST_SEND;
        end
      end
      ST_SEND: begin
        // reads go wait for returns, writebacks respond directly
        if (pkt_fire && last_flit) begin
          state_n = (op_r == CMD_READ) ? ST_WAIT_RET : ST_RESP;
        end
      end
      ST_WAIT_RET: begin
        if (all_returned_i) begin
          state_n = ST_RESP;
        end
      end
      ST_RESP: begin
        if (resp_ready_i) begin
          state_n = ST_IDLE;
        end
      end
      default: state_n = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= ST_IDLE;
      op_r <= CMD_WRITEBACK;
      flit_idx_r <= '0;
    end else begin
      state_r <= state_n;
      if (load_en_o) begin
        op_r <= cmd_op_i;
      end
      // wraps back to zero after the last flit
      if (pkt_fire) begin
        flit_idx_r <= flit_idx_r + 1'b1;
      end
    end
  end

endmodule

//--- hw/block_buffer.sv
//////////////////////////////////////////////////////////////////////
// holds the command in flight and its cache block; read returns
// overwrite their word so the block doubles as response data
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module block_buffer (
  input  logic                                    clk_i
  , input  logic                                  reset_i
  , input  logic                                  load_en_i
  , input  link_bridge_pkg::cmd_op_e              cmd_op_i
  , input  logic [link_bridge_pkg::BP_ADDR_W-1:0] cmd_addr_i
  , input  logic [link_bridge_pkg::TAG_W-1:0]     cmd_tag_i
  , input  logic [link_bridge_pkg::BLOCK_W-1:0]   cmd_data_i
  , input  logic [link_bridge_pkg::FLIT_IDX_W-1:0] flit_idx_i
  , input  logic                                  ret_wr_en_i
  , input  logic [link_bridge_pkg::FLIT_IDX_W-1:0] ret_slot_i
  , input  logic [link_bridge_pkg::LINK_DATA_W-1:0] ret_data_i
  , output link_bridge_pkg::cmd_op_e              op_o
  , output logic [link_bridge_pkg::BP_ADDR_W-1:0] addr_o
  , output logic [link_bridge_pkg::TAG_W-1:0]     tag_o
  , output logic [link_bridge_pkg::LINK_DATA_W-1:0] flit_o
  , output logic [link_bridge_pkg::BLOCK_W-1:0]   block_o
);

  import link_bridge_pkg::*;

  cmd_op_e op_r;
  logic [BP_ADDR_W-1:0] addr_r;
  logic [TAG_W-1:0] tag_r;
  logic [NUM_FLITS-1:0][LINK_DATA_W-1:0] block_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      op_r <= CMD_WRITEBACK;
    end else if (load_en_i) begin
      op_r <= cmd_op_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_en_i) begin
      addr_r <= cmd_addr_i;
      tag_r <= cmd_tag_i;
      block_r <= cmd_data_i;
    end else if (ret_wr_en_i) begin
      block_r[ret_slot_i] <= ret_data_i;
    end
  end

  assign op_o = op_r;
  assign addr_o = addr_r;
  assign tag_o = tag_r;
  // word 0 is the low end of the block
  assign flit_o = block_r[flit_idx_i];
  assign block_o = block_r;

endmodule

//--- hw/packet_former.sv
//////////////////////////////////////////////////////////////////////
// forms the mesh packet fields for the current flit of the held
// command; purely combinational
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module packet_former (
  input  link_bridge_pkg::cmd_op_e                 op_i
  , input  logic [link_bridge_pkg::BP_ADDR_W-1:0]   addr_i
  , input  logic [link_bridge_pkg::FLIT_IDX_W-1:0]  flit_idx_i
  , input  logic [link_bridge_pkg::LINK_DATA_W-1:0] flit_i
  , input  logic [link_bridge_pkg::X_W-1:0]         my_x_i
  , input  logic [link_bridge_pkg::Y_W-1:0]         my_y_i
  , output link_bridge_pkg::pkt_op_e                pkt_op_o
  , output logic [link_bridge_pkg::LINK_ADDR_W-1:0] pkt_addr_o
  , output logic [link_bridge_pkg::X_W-1:0]         pkt_x_o
  , output logic [link_bridge_pkg::Y_W-1:0]         pkt_y_o
  , output logic [link_bridge_pkg::X_W-1:0]         pkt_src_x_o
  , output logic [link_bridge_pkg::Y_W-1:0]         pkt_src_y_o
  , output logic [link_bridge_pkg::FLIT_IDX_W-1:0]  pkt_load_id_o
  , output logic [link_bridge_pkg::LINK_DATA_W-1:0] pkt_data_o
);

  import link_bridge_pkg::*;

  assign pkt_op_o = (op_i == CMD_READ) ? PKT_LOAD : PKT_STORE;

  // word address: zero msb, block bits, flit index
  assign pkt_addr_o = {1'b0, addr_i[BLK_LSB +: BLK_ADDR_W], flit_idx_i};

  // memory lives one row below this node
  assign pkt_x_o = addr_i[X_LSB +: X_W];
  assign pkt_y_o = Y_W'(my_y_i + 1'b1);

  assign pkt_src_x_o = my_x_i;
  assign pkt_src_y_o = my_y_i;
  assign pkt_load_id_o = flit_idx_i;

  // loads carry no payload
  assign pkt_data_o = (op_i == CMD_READ) ? '0 : flit_i;

endmodule

//--- hw/return_tracker.sv
//////////////////////////////////////////////////////////////////////
// tracks which flits of a read have come back; duplicate load ids
// are dropped and completion is flagged once every slot is filled
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module return_tracker (
  input  logic                                     clk_i
  , input  logic                                   reset_i
  , input  logic                                   clear_i
  , input  logic                                   ret_valid_i
  , input  logic                                   ret_ready_i
  , input  logic [link_bridge_pkg::FLIT_IDX_W-1:0] ret_load_id_i
  , output logic                                   ret_wr_en_o
  , output logic [link_bridge_pkg::FLIT_IDX_W-1:0] ret_slot_o
  , output logic                                   all_returned_o
);

  import link_bridge_pkg::*;

  logic [NUM_FLITS-1:0] mask_r;
  logic [NUM_FLITS-1:0] fill_set;

  // only a slot not yet filled gets written
  assign ret_wr_en_o = ret_valid_i & ret_ready_i & ~mask_r[ret_load_id_i];
  assign ret_slot_o = ret_load_id_i;

  assign fill_set = ret_wr_en_o ? (NUM_FLITS'(1) << ret_load_id_i) : '0;

  // include the return landing this cycle so the controller
  // leaves the wait state right after the last one
  assign all_returned_o = &(mask_r | fill_set);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mask_r <= '0;
    end else if (clear_i) begin
      mask_r <= '0;
    end else begin
      mask_r <= mask_r | fill_set;
    end
  end

endmodule

//--- hw/link_bridge_top.sv
//////////////////////////////////////////////////////////////////////
// memory port to mesh endpoint bridge; one command in flight, split
// into per-word store or load packets
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module link_bridge_top (
  input  logic                                     clk_i
  , input  logic                                   reset_i
  , input  logic [link_bridge_pkg::X_W-1:0]         my_x_i
  , input  logic [link_bridge_pkg::Y_W-1:0]         my_y_i
  // memory command
  , input  logic                                   cmd_valid_i
  , input  link_bridge_pkg::cmd_op_e               cmd_op_i
  , input  logic [link_bridge_pkg::BP_ADDR_W-1:0]   cmd_addr_i
  , input  logic [link_bridge_pkg::TAG_W-1:0]       cmd_tag_i
  , input  logic [link_bridge_pkg::BLOCK_W-1:0]     cmd_data_i
  , output logic                                   cmd_ready_o
  // network packet out
  , output logic                                   pkt_valid_o
  , output link_bridge_pkg::pkt_op_e               pkt_op_o
  , output logic [link_bridge_pkg::LINK_ADDR_W-1:0] pkt_addr_o
  , output logic [link_bridge_pkg::X_W-1:0]         pkt_x_o
  , output logic [link_bridge_pkg::Y_W-1:0]         pkt_y_o
  , output logic [link_bridge_pkg::X_W-1:0]         pkt_src_x_o
  , output logic [link_bridge_pkg::Y_W-1:0]         pkt_src_y_o
  , output logic [link_bridge_pkg::FLIT_IDX_W-1:0]  pkt_load_id_o
  , output logic [link_bridge_pkg::LINK_DATA_W-1:0] pkt_data_o
  , input  logic                                   pkt_ready_i
  // network load return
  , input  logic                                   ret_valid_i
  , input  logic [link_bridge_pkg::FLIT_IDX_W-1:0]  ret_load_id_i
  , input  logic [link_bridge_pkg::LINK_DATA_W-1:0] ret_data_i
  , output logic                                   ret_ready_o
  // memory response
  , output logic                                   resp_valid_o
  , output link_bridge_pkg::cmd_op_e               resp_op_o
  , output logic [link_bridge_pkg::BP_ADDR_W-1:0]   resp_addr_o
  , output logic [link_bridge_pkg::TAG_W-1:0]       resp_tag_o
  , output logic [link_bridge_pkg::BLOCK_W-1:0]     resp_data_o
  , input  logic                                   resp_ready_i
);

  import link_bridge_pkg::*;

  logic load_en;
  logic tracker_clear;
  logic all_returned;
  logic ret_wr_en;
  logic [FLIT_IDX_W-1:0] flit_idx;
  logic [FLIT_IDX_W-1:0] ret_slot;
  logic [LINK_DATA_W-1:0] cur_flit;

  link_bridge_ctrl u_ctrl (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cmd_valid_i     (cmd_valid_i),
    .cmd_op_i        (cmd_op_i),
    .pkt_ready_i     (pkt_ready_i),
    .all_returned_i  (all_returned),
    .resp_ready_i    (resp_ready_i),
    .cmd_ready_o     (cmd_ready_o),
    .load_en_o       (load_en),
    .pkt_valid_o     (pkt_valid_o),
    .flit_idx_o      (flit_idx),
    .tracker_clear_o (tracker_clear),
    .ret_ready_o     (ret_ready_o),
    .resp_valid_o    (resp_valid_o)
  );

  // held command fields feed the response directly
  block_buffer u_buffer (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .load_en_i   (load_en),
    .cmd_op_i    (cmd_op_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_tag_i   (cmd_tag_i),
    .cmd_data_i  (cmd_data_i),
    .flit_idx_i  (flit_idx),
    .ret_wr_en_i (ret_wr_en),
    .ret_slot_i  (ret_slot),
    .ret_data_i  (ret_data_i),
    .op_o        (resp_op_o),
    .addr_o      (resp_addr_o),
    .tag_o       (resp_tag_o),
    .flit_o      (cur_flit),
    .block_o     (resp_data_o)
  );

  packet_former u_former (
    .op_i          (resp_op_o),
    .addr_i        (resp_addr_o),
    .flit_idx_i    (flit_idx),
    .flit_i        (cur_flit),
    .my_x_i        (my_x_i),
    .my_y_i        (my_y_i),
    .pkt_op_o      (pkt_op_o),
    .pkt_addr_o    (pkt_addr_o),
    .pkt_x_o       (pkt_x_o),
    .pkt_y_o       (pkt_y_o),
    .pkt_src_x_o   (pkt_src_x_o),
    .pkt_src_y_o   (pkt_src_y_o),
    .pkt_load_id_o (pkt_load_id_o),
    .pkt_data_o    (pkt_data_o)
  );

  return_tracker u_tracker (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .clear_i        (tracker_clear),
    .ret_valid_i    (ret_valid_i),
    .ret_ready_i    (ret_ready_o),
    .ret_load_id_i  (ret_load_id_i),
    .ret_wr_en_o    (ret_wr_en),
    .ret_slot_o     (ret_slot),
    .all_returned_o (all_returned)
  );

endmodule

//--- sim/link_bridge_assert.sv
//////////////////////////////////////////////////////////////////////
// handshake and reset properties, bound onto the bridge top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module link_bridge_assert (
  input  logic clk_i
  , input  logic reset_i
  , input  logic cmd_valid_i
  , input  logic cmd_ready_i
  , input  logic pkt_valid_i
  , input  logic pkt_ready_i
  , input  logic [link_bridge_pkg::LINK_ADDR_W + 2 * (link_bridge_pkg::X_W + link_bridge_pkg::Y_W)
                  + link_bridge_pkg::FLIT_IDX_W + link_bridge_pkg::LINK_DATA_W:0] pkt_fields_i
  , input  logic ret_ready_i
  , input  logic resp_valid_i
  , input  logic resp_ready_i
  , input  logic [link_bridge_pkg::BP_ADDR_W + link_bridge_pkg::TAG_W
                  + link_bridge_pkg::BLOCK_W:0] resp_fields_i
);

  logic in_flight;

  // set by an accepted command, cleared by its response
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      in_flight <= 1'b0;
    end else if (cmd_valid_i && cmd_ready_i) begin
      in_flight <= 1'b1;
    end else if (resp_valid_i && resp_ready_i) begin
      in_flight <= 1'b0;
    end
  end

  a_reset_idle: assert property (@(posedge clk_i)
    reset_i |=> (cmd_ready_i && !pkt_valid_i && !ret_ready_i && !resp_valid_i))
    else $error("handshake outputs not idle after reset");

  // held until accepted
  a_pkt_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (pkt_valid_i && !pkt_ready_i) |=> (pkt_valid_i && $stable(pkt_fields_i)))
    else $error("packet dropped or changed before acceptance");

  a_resp_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (resp_valid_i && !resp_ready_i) |=> (resp_valid_i && $stable(resp_fields_i)))
    else $error("response dropped or changed before acceptance");

  // commands only taken when nothing is in flight
  a_no_cmd_in_flight: assert property (@(posedge clk_i) disable iff (reset_i)
    in_flight |-> !cmd_ready_i)
    else $error("command ready while a command is in flight");

  a_resp_in_flight: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_valid_i |-> in_flight)
    else $error("response offered without a command in flight");

endmodule

bind link_bridge_top link_bridge_assert u_assert (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .cmd_valid_i   (cmd_valid_i),
  .cmd_ready_i   (cmd_ready_o),
  .pkt_valid_i   (pkt_valid_o),
  .pkt_ready_i   (pkt_ready_i),
  .pkt_fields_i  ({pkt_op_o, pkt_addr_o, pkt_x_o, pkt_y_o, pkt_src_x_o, pkt_src_y_o,
                   pkt_load_id_o, pkt_data_o}),
  .ret_ready_i   (ret_ready_o),
  .resp_valid_i  (resp_valid_o),
  .resp_ready_i  (resp_ready_i),
  .resp_fields_i ({resp_op_o, resp_addr_o, resp_tag_o, resp_data_o})
);

//--- sim/link_bridge_tb.sv
//////////////////////////////////////////////////////////////////////
// testbench for the link bridge: file driven commands, a mesh memory
// model that answers loads out of order, packet and response checks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module link_bridge_tb;

  import link_bridge_pkg::*;

  localparam int CLK_HALF = 20;
  localparam int RESET_CYCLES = 16;
  localparam int CYCLES_PER_CMD = 200;
  localparam int RESP_LATENCY = 5;

  logic clk_i = 1'b0;
  logic reset_i;
  logic [X_W-1:0] my_x_i, pkt_x_o, pkt_src_x_o;
  logic [Y_W-1:0] my_y_i, pkt_y_o, pkt_src_y_o;
  logic cmd_valid_i, cmd_ready_o, pkt_valid_o, pkt_ready_i;
  logic ret_valid_i, ret_ready_o, resp_valid_o, resp_ready_i;
  cmd_op_e cmd_op_i, resp_op_o;
  pkt_op_e pkt_op_o;
  logic [BP_ADDR_W-1:0] cmd_addr_i, resp_addr_o;
  logic [TAG_W-1:0] cmd_tag_i, resp_tag_o;
  logic [BLOCK_W-1:0] cmd_data_i, resp_data_o;
  logic [LINK_ADDR_W-1:0] pkt_addr_o;
  logic [FLIT_IDX_W-1:0] pkt_load_id_o, ret_load_id_i;
  logic [LINK_DATA_W-1:0] pkt_data_o, ret_data_i;

  int seed = 32'h75f25f2d;
  int cyc = 0;
  int errors = 0;
  int n_cmds = 0;
  bit loaded = 1'b0;
  cmd_op_e tv_op[$];
  logic [BP_ADDR_W-1:0] tv_addr[$];
  logic [TAG_W-1:0] tv_tag[$];
  logic [BLOCK_W-1:0] tv_data[$];
  // mesh memory keyed by destination x, y and word address
  logic [LINK_DATA_W-1:0] net_mem [logic [X_W+Y_W+LINK_ADDR_W-1:0]];

  link_bridge_top DUT (.*);

  always #CLK_HALF clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic report_error(input string msg);
    errors++;
    abort_run($sformatf("ERR @%0t: %s", $time, msg));
  endtask

  // word address from the block number of the byte address and the flit index
  function automatic logic [LINK_ADDR_W-1:0] word_addr(input logic [BP_ADDR_W-1:0] addr,
                                                       input int f);
    return LINK_ADDR_W'((addr / (BLOCK_W / 8)) % (1 << (LINK_ADDR_W - 1 - FLIT_IDX_W))
                        * NUM_FLITS + f);
  endfunction

  task automatic check_flags(input logic cmd_rdy, input logic pkt_v, input logic ret_rdy,
                             input logic resp_v);
    if ({cmd_ready_o, pkt_valid_o, ret_ready_o, resp_valid_o} !==
        {cmd_rdy, pkt_v, ret_rdy, resp_v}) begin
      report_error($sformatf("cmd_rdy/pkt_v/ret_rdy/resp_v %b%b%b%b, expected %b%b%b%b",
        cmd_ready_o, pkt_valid_o, ret_ready_o, resp_valid_o, cmd_rdy, pkt_v, ret_rdy, resp_v));
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    if (got != exp) begin
      report_error($sformatf("response after %0d cycles, expected %0d", got, exp));
    end
  endtask

  task automatic check_pkt(input pkt_op_e op, input logic [LINK_ADDR_W-1:0] addr,
                           input logic [X_W-1:0] x, input logic [Y_W-1:0] y,
                           input logic [FLIT_IDX_W-1:0] id, input logic [LINK_DATA_W-1:0] data);
    if (pkt_op_o !== op || pkt_addr_o !== addr || pkt_x_o !== x || pkt_y_o !== y ||
        pkt_src_x_o !== my_x_i || pkt_src_y_o !== my_y_i || pkt_load_id_o !== id ||
        pkt_data_o !== data) begin
      report_error($sformatf("packet %s a=%h x=%h y=%h src=%h,%h id=%0d d=%h, expected %s %h %h %h %0d %h",
        pkt_op_o.name(), pkt_addr_o, pkt_x_o, pkt_y_o, pkt_src_x_o, pkt_src_y_o, pkt_load_id_o,
        pkt_data_o, op.name(), addr, x, y, id, data));
    end
  endtask

  task automatic check_resp(input cmd_op_e op, input logic [BP_ADDR_W-1:0] addr,
                            input logic [TAG_W-1:0] tag, input logic [BLOCK_W-1:0] blk);
    if (resp_op_o !== op || resp_addr_o !== addr || resp_tag_o !== tag || resp_data_o !== blk) begin
      report_error($sformatf("response %s a=%h tag=%h d=%h, expected %s a=%h tag=%h d=%h",
        resp_op_o.name(), resp_addr_o, resp_tag_o, resp_data_o, op.name(), addr, tag, blk));
    end
  endtask

  // one command from acceptance to response, called on a falling edge
  task automatic run_cmd(input int n);
    cmd_op_e op;
    logic [BP_ADDR_W-1:0] addr;
    logic [BLOCK_W-1:0] exp_blk;
    logic [LINK_ADDR_W-1:0] waddr;
    logic [LINK_DATA_W-1:0] word;
    logic [X_W-1:0] dx;
    logic [Y_W-1:0] dy;
    logic [FLIT_IDX_W-1:0] loads[$];
    logic [FLIT_IDX_W-1:0] tmp;
    bit stall;
    int t0;
    int j;
    int slot;
    op = tv_op[n];
    addr = tv_addr[n];
    exp_blk = tv_data[n];
    stall = (n != 0);
    dx = X_W'(addr >> (BYTE_OFF_W + LINK_ADDR_W - 1));
    dy = my_y_i + 1'b1;
    cmd_valid_i = 1'b1;
    cmd_op_i = op;
    cmd_addr_i = addr;
    cmd_tag_i = tv_tag[n];
    cmd_data_i = tv_data[n];
    #1;
    check_flags(1'b1, 1'b0, 1'b0, 1'b0);
    t0 = cyc;
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
    for (int f = 0; f < NUM_FLITS; f++) begin
      waddr = word_addr(addr, f);
      word = (op == CMD_READ) ? '0 : tv_data[n][f*LINK_DATA_W +: LINK_DATA_W];
      do begin
        pkt_ready_i = !stall || (($random(seed) & 3) != 0);
        #1;
        check_flags(1'b0, 1'b1, 1'b0, 1'b0);
        check_pkt((op == CMD_READ) ? PKT_LOAD : PKT_STORE, waddr, dx, dy, FLIT_IDX_W'(f), word);
        @(negedge clk_i);
      end while (!pkt_ready_i);
      if (op == CMD_READ) begin
        loads.push_back(FLIT_IDX_W'(f));
      end else begin
        net_mem[{dx, dy, waddr}] = word;
      end
    end
    pkt_ready_i = 1'b0;
    if (op == CMD_READ) begin
      // shuffle the return order
      for (int i = NUM_FLITS - 1; i > 0; i--) begin
        j = $unsigned($random(seed)) % (i + 1);
        tmp = loads[i];
        loads[i] = loads[j];
        loads[j] = tmp;
      end
      foreach (loads[i]) begin
        slot = int'(loads[i]);
        waddr = word_addr(addr, slot);
        // unwritten words read back as their own word address
        word = net_mem.exists({dx, dy, waddr}) ? net_mem[{dx, dy, waddr}] : LINK_DATA_W'(waddr);
        exp_blk[slot*LINK_DATA_W +: LINK_DATA_W] = word;
        ret_valid_i = 1'b1;
        ret_load_id_i = loads[i];
        ret_data_i = word;
        #1;
        check_flags(1'b0, 1'b0, 1'b1, 1'b0);
        @(negedge clk_i);
        if (i == 0) begin
          // a repeated load id must leave its slot untouched
          ret_data_i = ~word;
          #1;
          check_flags(1'b0, 1'b0, 1'b1, 1'b0);
          @(negedge clk_i);
        end
      end
      ret_valid_i = 1'b0;
    end
    do begin
      resp_ready_i = !stall || (($random(seed) & 1) != 0);
      #1;
      if (n == 0) begin
        check_latency(cyc - t0, RESP_LATENCY);
      end
      check_flags(1'b0, 1'b0, 1'b0, 1'b1);
      check_resp(op, addr, tv_tag[n], exp_blk);
      @(negedge clk_i);
    end while (!resp_ready_i);
    resp_ready_i = 1'b0;
  endtask

  initial begin
    int fd;
    string line;
    bit got_xy;
    int x_v;
    int y_v;
    int op_v;
    logic [31:0] a_v, t_v, w0, w1, w2, w3;
    reset_i = 1'b1;
    my_x_i = '0;
    my_y_i = '0;
    cmd_valid_i = 1'b0;
    cmd_op_i = CMD_WRITEBACK;
    cmd_addr_i = '0;
    cmd_tag_i = '0;
    cmd_data_i = '0;
    pkt_ready_i = 1'b0;
    ret_valid_i = 1'b0;
    ret_load_id_i = '0;
    ret_data_i = '0;
    resp_ready_i = 1'b0;
    got_xy = 1'b0;
    fd = $fopen("sim/link_bridge_input.txt", "r");
    if (fd == 0) begin
      abort_run("could not open the stimulus file sim/link_bridge_input.txt");
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) break;
      if (line.len() < 2 || line.substr(0, 0) == "#") continue;
      if (!got_xy) begin
        void'($sscanf(line, "%h %h", x_v, y_v));
        my_x_i = X_W'(x_v);
        my_y_i = Y_W'(y_v);
        got_xy = 1'b1;
      end else if ($sscanf(line, "%h %h %h %h %h %h %h", op_v, a_v, t_v, w0, w1, w2, w3) == 7) begin
        tv_op.push_back((op_v == 1) ? CMD_READ : CMD_WRITEBACK);
        tv_addr.push_back(a_v);
        tv_tag.push_back(TAG_W'(t_v));
        tv_data.push_back({w3, w2, w1, w0});
      end
    end
    $fclose(fd);
    n_cmds = tv_op.size();
    if (n_cmds == 0 || tv_op[0] != CMD_WRITEBACK) begin
      abort_run("stimulus file must start with a writeback command");
    end
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    for (int n = 0; n < n_cmds; n++) begin
      run_cmd(n);
    end
    #1;
    check_flags(1'b1, 1'b0, 1'b0, 1'b0);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (loaded);
    repeat (RESET_CYCLES + CYCLES_PER_CMD * n_cmds) @(posedge clk_i);
    abort_run("timeout: the bridge stopped making progress and the run hung");
  end

endmodule

//--- sim/link_bridge_input.txt
# first data line: node x y (hex)
# then per command: op (0 writeback, 1 read) addr tag word0 word1 word2 word3, hex, word0 is flit 0
3 f
0 00003a40 11 a0a0a001 b1b1b102 c2c2c203 d3d3d304
1 00003a40 12 00000000 00000000 00000000 00000000
1 0001c7f0 13 ffffffff ffffffff ffffffff ffffffff
0 00025f80 24 01234567 89abcdef 76543210 fedcba98
0 000e1230 35 deadbeef 0badf00d 13579bdf 2468ace0
1 00025f80 46 11111111 22222222 33333333 44444444
0 00003a40 57 55555555 aaaaaaaa 33333333 cccccccc
1 00003a40 68 00000000 00000000 00000000 00000000
1 000e1230 79 00000000 00000000 00000000 00000000

//--- compile.f
hw/link_bridge_pkg.sv
hw/link_bridge_ctrl.sv
hw/block_buffer.sv
hw/packet_former.sv
hw/return_tracker.sv
hw/link_bridge_top.sv
sim/link_bridge_assert.sv
sim/link_bridge_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the link bridge testbench with Verilator and runs it from the project root

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module link_bridge_tb -f compile.f -o link_bridge_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/link_bridge_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
if ! grep -q "ALL TESTS PASSED" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0
